/* run_sim.sh */
#!/bin/sh
# Build and run the FC neuron testbench with Verilator.
# Exit status is 0 on pass and 1 on any failure.

cd "$(dirname "$0")" || exit 1

TOP=fc_neuron_tb
OBJ_DIR=obj_dir
LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module "$TOP" -Mdir "$OBJ_DIR" -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG" ]; then
    echo "simulation log is empty"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "result: fail"
    exit 1
fi

echo "result: pass"
exit 0

/* src/fc_mac_lane.sv */
/* One MAC lane with its own weight bank; weights have no reset and must be loaded
   while no vector is in flight. The counter wraps after FC_MAX_PAIRS elements. */
`default_nettype none

module fc_mac_lane #(
    parameter fc_pkg::cfg_target_e LANE_ID = fc_pkg::CFG_LANE0
) (
    input  wire logic                                clk,
    input  wire logic                                rst,

    // weight configuration
    input  wire logic                                cfg_we_i,
    input  wire fc_pkg::cfg_t                        cfg_i,

    // element stream
    input  wire logic                                in_valid_i,
    input  wire logic signed [fc_pkg::FC_DATA_W-1:0] in_elem_i,
    input  wire logic                                in_last_i,

    // partial sum toward the combiner
    output logic                                     psum_valid_o,
    output fc_pkg::psum_t                            psum_o
);
    import fc_pkg::*;

    logic signed [FC_DATA_W-1:0] weight_mem [FC_MAX_PAIRS];

    logic                        cfg_hit;
    logic [FC_ADDR_W-1:0]        elem_idx;
    logic signed [FC_ACC_W-1:0]  acc;

    logic signed [FC_DATA_W-1:0] cur_weight;
    logic signed [FC_PROD_W-1:0] product;
    logic signed [FC_ACC_W-1:0]  product_ext;
    logic signed [FC_ACC_W-1:0]  acc_next;
    logic                        vec_end;

    // only writes aimed at this lane land in the bank
    assign cfg_hit = cfg_we_i && (cfg_i.target == LANE_ID);

    always_ff @(posedge clk) begin
        if (cfg_hit) begin
            weight_mem[cfg_i.addr] <= cfg_i.word.weight.value;
        end
    end

    // weight for the current element
    assign cur_weight = weight_mem[elem_idx];

    // signed 8x8 product widened to accumulator width
    assign product     = in_elem_i * cur_weight;
    assign product_ext = {{(FC_ACC_W-FC_PROD_W){product[FC_PROD_W-1]}}, product};
    assign acc_next    = acc + product_ext;

    assign vec_end = in_valid_i && in_last_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            acc          <= '0;
            elem_idx     <= '0;
            psum_valid_o <= 1'b0;
        end else begin
            psum_valid_o <= vec_end;
            if (in_valid_i) begin
                if (in_last_i) begin
                    // ready for the next vector on the following cycle
                    acc      <= '0;
                    elem_idx <= '0;
                end else begin
                    acc      <= acc_next;
                    elem_idx <= elem_idx + 1'b1;
                end
            end
        end
    end

    // final sum includes the last product that is not yet in acc
    always_ff @(posedge clk) begin
        if (vec_end) begin
            psum_o.sum  <= acc_next;
            psum_o.last <= in_last_i;
        end
    end

endmodule

`default_nettype wire

/* src/fc_neuron_top.sv */
/* One fully connected neuron over paired activations. out_valid_o follows the
   last input strobe by 3 cycles; config writes only between vectors. */
`default_nettype none

module fc_neuron_top (
    input  wire logic              clk,
    input  wire logic              rst,

    // weight and bias configuration
    input  wire logic              cfg_we_i,
    input  wire fc_pkg::cfg_t      cfg_i,

    // activation pairs
    input  wire logic              in_valid_i,
    input  wire fc_pkg::act_pair_t in_pair_i,

    // requantized output, one per vector
    output logic                   out_valid_o,
    output fc_pkg::act_out_t       out_o
);
    import fc_pkg::*;

    logic  lane_psum_valid;
    psum_t lane0_psum;
    psum_t lane1_psum;

    logic  sum_valid;
    psum_t sum;

    // even elements
    fc_mac_lane #(
        .LANE_ID      (CFG_LANE0)
    ) u_lane0 (
        .clk          (clk),
        .rst          (rst),
        .cfg_we_i     (cfg_we_i),
        .cfg_i        (cfg_i),
        .in_valid_i   (in_valid_i),
        .in_elem_i    (in_pair_i.even),
        .in_last_i    (in_pair_i.last),
        .psum_valid_o (lane_psum_valid),
        .psum_o       (lane0_psum)
    );

    // odd elements with the strobe left open since it matches lane 0
    fc_mac_lane #(
        .LANE_ID      (CFG_LANE1)
    ) u_lane1 (
        .clk          (clk),
        .rst          (rst),
        .cfg_we_i     (cfg_we_i),
        .cfg_i        (cfg_i),
        .in_valid_i   (in_valid_i),
        .in_elem_i    (in_pair_i.odd),
        .in_last_i    (in_pair_i.last),
        .psum_valid_o (),
        .psum_o       (lane1_psum)
    );

    fc_partial_combiner u_combiner (
        .clk          (clk),
        .rst          (rst),
        .cfg_we_i     (cfg_we_i),
        .cfg_i        (cfg_i),
        .psum_valid_i (lane_psum_valid),
        .psum_a_i     (lane0_psum),
        .psum_b_i     (lane1_psum),
        .sum_valid_o  (sum_valid),
        .sum_o        (sum)
    );

    fc_relu_quant u_relu (
        .clk          (clk),
        .rst          (rst),
        .sum_valid_i  (sum_valid),
        .sum_i        (sum),
        .act_valid_o  (out_valid_o),
        .act_o        (out_o)
    );

endmodule

`default_nettype wire

/* src/fc_partial_combiner.sv */
/* Adds both lane partial sums and the bias. Lane strobes must coincide, so only
   lane a's strobe and last are used. The bias resets to 0. */
`default_nettype none

module fc_partial_combiner (
    input  wire logic          clk,
    input  wire logic          rst,

    // bias configuration
    input  wire logic          cfg_we_i,
    input  wire fc_pkg::cfg_t  cfg_i,

    // partial sums from the lanes
    input  wire logic          psum_valid_i,
    input  wire fc_pkg::psum_t psum_a_i,
    input  wire fc_pkg::psum_t psum_b_i,

    // biased total
    output logic               sum_valid_o,
    output fc_pkg::psum_t      sum_o
);
    import fc_pkg::*;

    logic signed [FC_BIAS_W-1:0] bias_q;
    logic signed [FC_ACC_W-1:0]  bias_ext;
    logic signed [FC_ACC_W-1:0]  total;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bias_q <= '0;
        end else if (cfg_we_i && (cfg_i.target == CFG_BIAS)) begin
            // same config word read through the bias view
            bias_q <= cfg_i.word.bias;
        end
    end

    assign bias_ext = {{(FC_ACC_W-FC_BIAS_W){bias_q[FC_BIAS_W-1]}}, bias_q};

    // wraps at accumulator width
    assign total = psum_a_i.sum + psum_b_i.sum + bias_ext;

    always_ff @(posedge clk) begin
        if (!rst) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= psum_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid_i) begin
            sum_o.sum  <= total;
            sum_o.last <= psum_a_i.last;
        end
    end

endmodule

`default_nettype wire

/* src/fc_pkg.sv */
/* Widths and stream types shared by the fully connected neuron.
   Vectors are limited to FC_MAX_PAIRS pairs; longer ones wrap the weight index. */
`default_nettype none

package fc_pkg;

    // datapath widths
    localparam int FC_DATA_W    = 8;
    localparam int FC_PROD_W    = 2 * FC_DATA_W;
    localparam int FC_ACC_W     = 24;
    localparam int FC_BIAS_W    = 16;

    // weight bank geometry per lane
    localparam int FC_MAX_PAIRS = 16;
    localparam int FC_ADDR_W    = 4;

    // requantization
    localparam int FC_ACT_SHIFT = 4;
    localparam int FC_OUT_MAX   = 127;

    // destination of a configuration write
    typedef enum logic [1:0] {
        CFG_LANE0 = 2'd0,
        CFG_LANE1 = 2'd1,
        CFG_BIAS  = 2'd2
    } cfg_target_e;

    // weight view keeps the byte in the low half of the word
    typedef struct packed {
        logic [FC_BIAS_W-FC_DATA_W-1:0] pad;
        logic signed [FC_DATA_W-1:0]    value;
    } cfg_weight_view_t;

    // one config word that the lanes read as a weight and the combiner as a bias
    typedef union packed {
        cfg_weight_view_t            weight;
        logic signed [FC_BIAS_W-1:0] bias;
    } cfg_word_u;

    typedef struct packed {
        cfg_target_e          target;
        logic [FC_ADDR_W-1:0] addr;
        cfg_word_u            word;
    } cfg_t;

    // input stream with one pair per strobe
    typedef struct packed {
        logic signed [FC_DATA_W-1:0] even;
        logic signed [FC_DATA_W-1:0] odd;
        logic                        last;
    } act_pair_t;

    typedef struct packed {
        logic signed [FC_ACC_W-1:0] sum;
        logic                       last;
    } psum_t;

    typedef struct packed {
        logic [FC_DATA_W-1:0] result;
        logic                 last;
    } act_out_t;

endpackage

`default_nettype wire

/* src/fc_relu_quant.sv */
/* ReLU and requantize to one byte in 0..FC_OUT_MAX, one registered stage.
   No back-pressure; the consumer takes every valid result. */
`default_nettype none

module fc_relu_quant (
    input  wire logic          clk,
    input  wire logic          rst,

    input  wire logic          sum_valid_i,
    input  wire fc_pkg::psum_t sum_i,

    output logic               act_valid_o,
    output fc_pkg::act_out_t   act_o
);
    import fc_pkg::*;

    logic signed [FC_ACC_W-1:0] shifted;
    logic                       is_neg;
    logic [FC_DATA_W-1:0]       quant;

    assign is_neg  = sum_i.sum[FC_ACC_W-1];

    // arithmetic shift keeps the sign, though negatives are zeroed anyway
    assign shifted = sum_i.sum >>> FC_ACT_SHIFT;

    always_comb begin
        if (is_neg) begin
            // relu
            quant = '0;
        end else if (shifted > FC_OUT_MAX) begin
            quant = FC_DATA_W'(FC_OUT_MAX);
        end else begin
            quant = shifted[FC_DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            act_valid_o <= 1'b0;
        end else begin
            act_valid_o <= sum_valid_i;
        end
    end

    // result and last move together
    always_ff @(posedge clk) begin
        if (sum_valid_i) begin
            act_o.result <= quant;
            act_o.last   <= sum_i.last;
        end
    end

endmodule

`default_nettype wire

/* test/fc_neuron_tb.sv */
/* Self-checking testbench for the FC neuron. Vectors stay within 16 pairs, and
   config is only rewritten once the pipeline has drained. */
`default_nettype none

module fc_neuron_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fc_pkg::*;

    localparam int CLK_HALF     = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int PIPE_LATENCY = 3;

    // each config load writes both banks and the bias and then idles one cycle
    localparam int CFG_CYCLES  = 2 * FC_MAX_PAIRS + 2;
    localparam int RAND_RUNS   = 20;
    localparam int NUM_LOADS   = 5 + RAND_RUNS;
    localparam int NUM_VECTORS = 11 + RAND_RUNS;
    localparam int FIXED_PAIRS = 28 + 12 + 18 + 25;
    localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_LOADS * CFG_CYCLES + FIXED_PAIRS
                               + RAND_RUNS * FC_MAX_PAIRS + NUM_VECTORS * 10;

    typedef logic signed [FC_DATA_W-1:0] elem_arr_t [FC_MAX_PAIRS];

    logic      clk;
    logic      rst;
    logic      cfg_we;
    cfg_t      cfg;
    logic      in_valid;
    act_pair_t in_pair;
    logic      out_valid;
    act_out_t  out_act;

    // weights, bias and the current vector
    elem_arr_t                   w0;
    elem_arr_t                   w1;
    logic signed [FC_BIAS_W-1:0] bias;
    elem_arr_t                   ev;
    elem_arr_t                   od;

    int cycle_cnt = 0;
    int check_cnt = 0;
    int err_cnt   = 0;
    int exp_res_q [$];
    int exp_cyc_q [$];

    fc_neuron_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .cfg_we_i    (cfg_we),
        .cfg_i       (cfg),
        .in_valid_i  (in_valid),
        .in_pair_i   (in_pair),
        .out_valid_o (out_valid),
        .out_o       (out_act)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, %0d outputs never arrived",
                 cycle_cnt, exp_res_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    // dot product plus bias followed by relu, shift and clamp
    function automatic int ref_neuron(input elem_arr_t wa, input elem_arr_t wb,
                                      input logic signed [FC_BIAS_W-1:0] b,
                                      input elem_arr_t ea, input elem_arr_t ob,
                                      input int n);
        int total;
        total = int'(b);
        for (int i = 0; i < n; i++) begin
            total += int'(ea[i]) * int'(wa[i]) + int'(ob[i]) * int'(wb[i]);
        end
        if (total < 0) begin
            return 0;
        end
        total = total >>> FC_ACT_SHIFT;
        if (total > FC_OUT_MAX) begin
            return FC_OUT_MAX;
        end
        return total;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        int exp_res;
        int exp_cyc;
        if (rst && out_valid) begin
            if (exp_res_q.size() == 0) begin
                err_cnt++;
                $display("output at %0t ns arrived with no vector pending", $time);
            end else begin
                exp_res = exp_res_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                check_value("output byte", int'(out_act.result), exp_res);
                check_value("output last flag", int'(out_act.last), 1);
                check_value("output cycle", cycle_cnt, exp_cyc + PIPE_LATENCY);
            end
        end
    end

    task automatic write_cfg(input cfg_target_e tgt, input int addr,
                             input logic signed [FC_DATA_W-1:0] w);
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_we                = 1'b1;
        cfg.target            = tgt;
        cfg.addr              = FC_ADDR_W'(addr);
        // upper byte is junk in the weight view
        cfg.word.weight.pad   = 8'($urandom);
        cfg.word.weight.value = w;
    endtask

    task automatic load_config();
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            write_cfg(CFG_LANE0, i, w0[i]);
        end
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            write_cfg(CFG_LANE1, i, w1[i]);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cfg.target    = CFG_BIAS;
        cfg.addr      = '0;
        cfg.word.bias = bias;
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_we = 1'b0;
        cfg    = '0;
    endtask

    // leaves in_valid high so the next vector can follow with no gap
    task automatic send_vector(input int n);
        int expv;
        expv = ref_neuron(w0, w1, bias, ev, od, n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid     = 1'b1;
            in_pair.even = ev[i];
            in_pair.odd  = od[i];
            in_pair.last = (i == n - 1);
        end
        exp_res_q.push_back(expv);
        exp_cyc_q.push_back(cycle_cnt);
    endtask

    task automatic end_stream();
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        in_pair  = '0;
    endtask

    task automatic wait_drain();
        while (exp_res_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic send_and_drain(input int n);
        send_vector(n);
        end_stream();
        wait_drain();
    endtask

    task automatic fill_random_weights(input bit wide_bias);
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            w0[i] = FC_DATA_W'($urandom);
            w1[i] = FC_DATA_W'($urandom);
        end
        if (wide_bias) begin
            bias = FC_BIAS_W'($urandom);
        end else begin
            bias = FC_BIAS_W'(int'($urandom_range(4095, 0)) - 2048);
        end
    endtask

    // activations in -span .. span-1
    task automatic fill_random_acts(input int span);
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            ev[i] = FC_DATA_W'(int'($urandom_range(2 * span - 1, 0)) - span);
            od[i] = FC_DATA_W'(int'($urandom_range(2 * span - 1, 0)) - span);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before,
                               input int vectors);
        $display("test %0d %s: %0d vectors, %0d errors", num, name, vectors,
                 err_cnt - errs_before);
    endtask

    initial begin
        int errs_before;
        int n;
        int span;
        int b2b_len [4];
        void'($urandom(32'h3553_50c6));
        b2b_len  = '{1, 3, 5, 16};
        rst      = 1'b0;
        cfg_we   = 1'b0;
        cfg      = '0;
        in_valid = 1'b0;
        in_pair  = '0;
        bias     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;

        // small positive weights and activations
        errs_before = err_cnt;
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            w0[i] = FC_DATA_W'(i + 1);
            w1[i] = FC_DATA_W'(2);
            ev[i] = FC_DATA_W'(i);
            od[i] = FC_DATA_W'(3);
        end
        bias = FC_BIAS_W'(5);
        load_config();
        send_and_drain(4);
        send_and_drain(8);
        send_and_drain(16);
        report_test(1, "positive dot products", errs_before, 3);

        // negative products first and then positive products pulled below zero by the bias
        errs_before = err_cnt;
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            w0[i] = FC_DATA_W'(7);
            w1[i] = FC_DATA_W'(3);
            ev[i] = FC_DATA_W'(-20);
            od[i] = FC_DATA_W'(-5);
        end
        bias = '0;
        load_config();
        send_and_drain(6);
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            w0[i] = FC_DATA_W'(5);
            w1[i] = FC_DATA_W'(5);
            ev[i] = FC_DATA_W'(10);
            od[i] = FC_DATA_W'(10);
        end
        bias = FC_BIAS_W'(-3000);
        load_config();
        send_and_drain(6);
        report_test(2, "negative totals", errs_before, 2);

        // extreme operands and maximum bias
        errs_before = err_cnt;
        for (int i = 0; i < FC_MAX_PAIRS; i++) begin
            w0[i] = FC_DATA_W'(-128);
            w1[i] = FC_DATA_W'(127);
            ev[i] = FC_DATA_W'(-128);
            od[i] = FC_DATA_W'(127);
        end
        bias = FC_BIAS_W'(32767);
        load_config();
        send_and_drain(16);
        send_and_drain(2);
        report_test(3, "saturation", errs_before, 2);

        // vectors with no idle cycle between them
        errs_before = err_cnt;
        fill_random_weights(1'b0);
        load_config();
        for (int k = 0; k < 4; k++) begin
            fill_random_acts(8);
            send_vector(b2b_len[k]);
        end
        end_stream();
        wait_drain();
        report_test(4, "back to back vectors", errs_before, 4);

        // random config and vectors reloaded for every run
        errs_before = err_cnt;
        for (int r = 0; r < RAND_RUNS; r++) begin
            fill_random_weights(r % 2 == 1);
            load_config();
            n    = 1 + int'($urandom_range(FC_MAX_PAIRS - 1, 0));
            span = (r % 4 == 3) ? 128 : 8;
            fill_random_acts(span);
            send_and_drain(n);
        end
        report_test(5, "random runs", errs_before, RAND_RUNS);

        $display("tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/fc_pkg.sv
src/fc_mac_lane.sv
src/fc_partial_combiner.sv
src/fc_relu_quant.sv
src/fc_neuron_top.sv
test/fc_neuron_tb.sv
